/* rv32_mc.f */
design/rv32_pkg.sv
design/rv32_prefetch.sv
design/rv32_decode.sv
design/rv32_registers.sv
design/rv32_alu.sv
design/rv32_memory.sv
design/rv32_mc_core.sv
tests/tb_rv32_mc.sv

/* run_sim.sh */
#!/bin/sh
# builds the rv32_mc testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rv32_mc -f rv32_mc.f

output=$(./obj_dir/Vtb_rv32_mc)
echo "$output"

# pass only when the testbench reports it
echo "$output" | grep -q "Simulation PASSED"

/* tests/tb_rv32_mc.sv */
`timescale 1ns/1ps

module tb_rv32_mc;

  localparam logic [31:0] RESET_PC    = 32'h0;
  localparam logic [31:0] RESULT_BASE = 32'h400;
  localparam logic [31:0] DATA_ADDR   = 32'h300;
  localparam logic [31:0] DATA_WORD   = 32'h1234_5678;
  localparam int          RUN_TIMEOUT = 20000;

  logic        clk_i = 1'b0;
  logic        reset_i = 1'b1;
  logic [31:0] dat_i = '0;
  logic        ack_i = 1'b0;
  logic [31:0] dat_o;
  logic [29:0] adr_o;
  logic [3:0]  sel_o;
  logic        cyc_o, stb_o, we_o, halted_o;
  logic [13:0] debug_o;

  logic [31:0] mem [0:1023];
  logic [9:0]  load_ptr = '0;
  logic [31:0] rng_state = 32'd82642;
  logic [1:0]  wait_left = '0;
  logic        busy = 1'b0;
  logic        first_seen = 1'b0;
  logic        prev_stb = 1'b0;
  logic        prev_we = 1'b0;
  logic [29:0] prev_adr = '0;
  logic [31:0] prev_dat = '0;
  int          errors = 0;
  int          checks = 0;
  string       exp_name[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_value[$];

  rv32_mc_core #(
    .RESET_PC(RESET_PC)
  ) u_rv32_mc_core (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .dat_i    (dat_i),
    .ack_i    (ack_i),
    .dat_o    (dat_o),
    .adr_o    (adr_o),
    .sel_o    (sel_o),
    .cyc_o    (cyc_o),
    .stb_o    (stb_o),
    .we_o     (we_o),
    .halted_o (halted_o),
    .debug_o  (debug_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // background words that are never executed
  function automatic logic [31:0] fill_value(input logic [9:0] idx);
    return 32'ha5a50000 ^ {12'b0, idx, 10'b0} ^ {22'b0, idx};
  endfunction

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv32_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input rv32_pkg::opcode_e op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv32_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv32_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input int imm, input int rd,
                                         input rv32_pkg::opcode_e op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv32_pkg::OP_JAL};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[load_ptr] = word;
    load_ptr++;
  endtask

  task automatic expect_word(input string name, input int off, input logic [31:0] value);
    exp_name.push_back(name);
    exp_addr.push_back(RESULT_BASE + off);
    exp_value.push_back(value);
  endtask

  // a jumped-over store leaves the fill word in place
  task automatic skipped_store(input string name, input int off);
    logic [31:0] addr;
    addr = RESULT_BASE + off;
    expect_word(name, off, fill_value(addr[11:2]));
  endtask

  // marker lands at off only on the taken path
  task automatic branch_case(input string name, input int f3, input int rs1, input int rs2,
                             input logic taken, input int id, input int off);
    logic [31:0] addr;
    addr = RESULT_BASE + off;
    emit(i_type(id, 0, 0, 13, rv32_pkg::OP_IMM));
    emit(b_type(8, rs2, rs1, f3));
    emit(j_type(8, 0));
    emit(s_type(off, 13, 10));
    expect_word(name, off, taken ? id : fill_value(addr[11:2]));
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_result(input string name, input logic [31:0] addr,
                              input logic [31:0] expected);
    logic [31:0] actual;
    actual = mem[addr[11:2]];
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // wishbone slave with random wait states and protocol checks
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (stb_o) begin
        assert (cyc_o) else report_problem("stb_o high while cyc_o is low");
        checks++;
        assert (sel_o == 4'b1111) else begin
          errors++;
          $display("FAIL sel_o expected %h actual %h", 4'b1111, sel_o);
        end
      end
      if (prev_stb && !ack_i) begin
        checks++;
        assert (stb_o && adr_o == prev_adr && we_o == prev_we && (!we_o || dat_o == prev_dat))
          else report_problem("master outputs changed during a wait state");
      end
      if (stb_o && !first_seen) begin
        first_seen = 1'b1;
        checks++;
        assert (adr_o == RESET_PC[31:2]) else begin
          errors++;
          $display("FAIL reset_pc expected %h actual %h", RESET_PC[31:2], adr_o);
        end
      end
      prev_stb = stb_o;
      prev_we  = we_o;
      prev_adr = adr_o;
      prev_dat = dat_o;
      if (ack_i) begin
        ack_i <= 1'b0;
      end else if (stb_o && cyc_o) begin
        if (!busy) begin
          busy      = 1'b1;
          rng_state = xorshift32(rng_state);
          wait_left = rng_state[1:0];
        end
        if (wait_left == 2'd0) begin
          busy = 1'b0;
          if (adr_o[29:10] != '0) begin
            report_problem("bus access outside the memory model");
          end
          if (we_o) begin
            mem[adr_o[9:0]] = dat_o;
          end else begin
            dat_i <= mem[adr_o[9:0]];
          end
          ack_i <= 1'b1;
        end else begin
          wait_left = wait_left - 2'd1;
        end
      end
    end
  end

  initial begin
    logic [31:0] va, vb, jal_addr, loop_addr;
    int          cycles;
    logic        timed_out;
    va = 32'd100;
    vb = -32'sd7;
    timed_out = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem[i[9:0]] = fill_value(i[9:0]);
    end
    mem[DATA_ADDR[11:2]] = DATA_WORD;

    emit(i_type(100, 0, 0, 1, rv32_pkg::OP_IMM));
    emit(i_type(-7, 0, 0, 2, rv32_pkg::OP_IMM));
    emit(i_type(32'h400, 0, 0, 10, rv32_pkg::OP_IMM));
    emit(i_type(2, 0, 0, 9, rv32_pkg::OP_IMM));
    emit(i_type(23, 1, 0, 3, rv32_pkg::OP_IMM));
    emit(s_type(0, 3, 10));
    emit(r_type(7'h20, 2, 1, 0, 4));
    emit(s_type(4, 4, 10));
    emit(r_type(0, 2, 1, 4, 5));
    emit(s_type(8, 5, 10));
    emit(r_type(0, 1, 2, 2, 6));
    emit(s_type(12, 6, 10));
    emit(r_type(0, 1, 2, 3, 7));
    emit(s_type(16, 7, 10));
    emit(r_type(7'h20, 9, 2, 5, 8));
    emit(s_type(20, 8, 10));
    emit(u_type(32'habcde, 11, rv32_pkg::OP_LUI));
    emit(s_type(24, 11, 10));
    emit(i_type(DATA_ADDR, 0, 2, 12, rv32_pkg::OP_LOAD));
    emit(i_type(1, 12, 0, 12, rv32_pkg::OP_IMM));
    emit(s_type(28, 12, 10));
    expect_word("addi", 0, va + 32'd23);
    expect_word("sub", 4, va - vb);
    expect_word("xor", 8, va ^ vb);
    expect_word("slt", 12, {31'b0, $signed(vb) < $signed(va)});
    expect_word("sltu", 16, {31'b0, vb < va});
    expect_word("sra", 20, 32'($signed(vb) >>> 2));
    expect_word("lui", 24, 32'habcde000);
    expect_word("load", 28, DATA_WORD + 32'd1);

    branch_case("beq", rv32_pkg::BEQ, 1, 1, va == va, 11, 32);
    branch_case("bne", rv32_pkg::BNE, 1, 1, va != va, 12, 36);
    branch_case("blt", rv32_pkg::BLT, 2, 1, $signed(vb) < $signed(va), 13, 40);
    branch_case("bge", rv32_pkg::BGE, 2, 1, $signed(vb) >= $signed(va), 14, 44);
    branch_case("bltu", rv32_pkg::BLTU, 2, 1, vb < va, 15, 48);
    branch_case("bgeu", rv32_pkg::BGEU, 2, 1, vb >= va, 16, 52);

    // jal and jalr each jump over one store
    jal_addr = {20'b0, load_ptr, 2'b00};
    emit(j_type(8, 15));
    emit(s_type(76, 2, 10));
    emit(s_type(64, 15, 10));
    emit(i_type(16, 15, 0, 16, rv32_pkg::OP_JALR));
    emit(s_type(80, 2, 10));
    emit(s_type(68, 16, 10));
    expect_word("jal_link", 64, jal_addr + 32'd4);
    expect_word("jalr_link", 68, jal_addr + 32'd16);
    skipped_store("jal_skip", 76);
    skipped_store("jalr_skip", 80);

    emit(i_type(55, 0, 0, 0, rv32_pkg::OP_IMM));
    emit(s_type(72, 0, 10));
    expect_word("x0", 72, 32'd0);
    loop_addr = {20'b0, load_ptr, 2'b00};
    emit(j_type(0, 0));

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    checks++;
    assert (!cyc_o && !stb_o && !we_o) else report_problem("bus not idle after reset");
    reset_i = 1'b0;

    cycles = 0;
    while (debug_o != loop_addr[15:2] && cycles < RUN_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= RUN_TIMEOUT) begin
      timed_out = 1'b1;
      report_problem("timeout waiting for the program to reach its final loop");
    end

    if (!timed_out) begin
      assert (!halted_o) else report_problem("core halted on an illegal instruction");
      for (int k = 0; k < exp_name.size(); k++) begin
        check_result(exp_name[k], exp_addr[k], exp_value[k]);
      end
    end

    $display("errors: %0d checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* design/rv32_mc_core.sv */
`timescale 1ns/1ps

module rv32_mc_core #(
  parameter logic [rv32_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [rv32_pkg::XLEN-1:0] dat_i,
  input  logic                      ack_i,
  output logic [rv32_pkg::XLEN-1:0] dat_o,
  output logic [rv32_pkg::XLEN-3:0] adr_o,
  output logic [3:0]                sel_o,
  output logic                      cyc_o,
  output logic                      stb_o,
  output logic                      we_o,
  output logic                      halted_o,
  output logic [13:0]               debug_o
);

  typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} core_state_e;

  // one-hot grant with bit 0 for prefetch and bit 1 for memory
  localparam logic [1:0] GRANT_PF  = 2'b01;
  localparam logic [1:0] GRANT_MEM = 2'b10;

  core_state_e                   state_q;
  logic [1:0]                    grant_q, bus_req;
  logic [rv32_pkg::XLEN-1:0]     pc_q, next_pc_q, wb_data_q, pc_plus4;

  logic                          pf_ready, pf_req, pf_cyc, pf_stb;
  logic [rv32_pkg::XLEN-1:0]     pf_instr;
  logic [rv32_pkg::XLEN-3:0]     pf_adr;

  logic [rv32_pkg::REG_BITS-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [rv32_pkg::XLEN-1:0]     immediate, rs1, rs2;
  rv32_pkg::alu_op_e             alu_op;
  rv32_pkg::branch_cond_e        branch_cond;
  logic use_imm, use_pc, jal, jalr, branch, load, store, reg_write, illegal;

  logic [rv32_pkg::XLEN-1:0]     alu_a, alu_b, alu_result;
  logic                          alu_equal, alu_less, alu_less_u, cond_true;

  logic                          mem_start, mem_done, mem_req, mem_cyc, mem_stb, mem_we;
  logic [rv32_pkg::XLEN-1:0]     mem_rdata, mem_dat_o;
  logic [rv32_pkg::XLEN-3:0]     mem_adr;
  logic [3:0]                    mem_sel;

  assign bus_req = {mem_req, pf_req};

  // move only off an idle owner with memory first
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grant_q <= GRANT_PF;
    end else if ((grant_q & bus_req) == 2'b00) begin
      if (mem_req) begin
        grant_q <= GRANT_MEM;
      end else if (pf_req) begin
        grant_q <= GRANT_PF;
      end
    end
  end

  assign cyc_o = grant_q[1] ? mem_cyc : pf_cyc;
  assign stb_o = grant_q[1] ? mem_stb : pf_stb;
  assign adr_o = grant_q[1] ? mem_adr : pf_adr;
  assign sel_o = mem_sel;
  assign we_o  = grant_q[1] & mem_we;
  assign dat_o = mem_dat_o;

  rv32_prefetch #(
    .RESET_PC(RESET_PC)
  ) u_prefetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .advance_i     (state_q == WRITEBACK),
    .pc_i          (next_pc_q),
    .data_ready_o  (pf_ready),
    .instruction_o (pf_instr),
    .ctrl_req_o    (pf_req),
    .ctrl_grant_i  (grant_q[0]),
    .dat_i         (dat_i),
    .ack_i         (ack_i),
    .adr_o         (pf_adr),
    .cyc_o         (pf_cyc),
    .stb_o         (pf_stb)
  );

  rv32_decode u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .data_ready_i  (pf_ready),
    .instruction_i (pf_instr),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rd_addr_o     (rd_addr),
    .immediate_o   (immediate),
    .alu_op_o      (alu_op),
    .use_imm_o     (use_imm),
    .use_pc_o      (use_pc),
    .jal_o         (jal),
    .jalr_o        (jalr),
    .branch_o      (branch),
    .load_o        (load),
    .store_o       (store),
    .reg_write_o   (reg_write),
    .branch_cond_o (branch_cond),
    .illegal_o     (illegal)
  );

  rv32_registers u_registers (
    .clk_i      (clk_i),
    .write_i    ((state_q == WRITEBACK) && reg_write),
    .rd_addr_i  (rd_addr),
    .data_i     (wb_data_q),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_o      (rs1),
    .rs2_o      (rs2)
  );

  assign alu_a = use_pc ? pc_q : rs1;
  assign alu_b = use_imm ? immediate : rs2;

  rv32_alu u_alu (
    .operation_i     (alu_op),
    .operand1_i      (alu_a),
    .operand2_i      (alu_b),
    .result_o        (alu_result),
    .equal_o         (alu_equal),
    .less_o          (alu_less),
    .less_unsigned_o (alu_less_u)
  );

  assign mem_start = (state_q == EXECUTE) && (load || store);

  rv32_memory u_memory (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .start_i      (mem_start),
    .write_i      (store),
    .addr_i       (alu_result),
    .data_i       (rs2),
    .data_o       (mem_rdata),
    .done_o       (mem_done),
    .ctrl_req_o   (mem_req),
    .ctrl_grant_i (grant_q[1]),
    .dat_i        (dat_i),
    .ack_i        (ack_i),
    .dat_o        (mem_dat_o),
    .adr_o        (mem_adr),
    .sel_o        (mem_sel),
    .cyc_o        (mem_cyc),
    .stb_o        (mem_stb),
    .we_o         (mem_we)
  );

  always_comb begin
    case (branch_cond)
      rv32_pkg::BEQ:  cond_true = alu_equal;
      rv32_pkg::BNE:  cond_true = !alu_equal;
      rv32_pkg::BLT:  cond_true = alu_less;
      rv32_pkg::BGE:  cond_true = !alu_less;
      rv32_pkg::BLTU: cond_true = alu_less_u;
      rv32_pkg::BGEU: cond_true = !alu_less_u;
      default:        cond_true = 1'b0;
    endcase
  end

  assign pc_plus4 = pc_q + 32'd4;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= FETCH;
      pc_q     <= RESET_PC;
      halted_o <= 1'b0;
    end else begin
      case (state_q)
        FETCH: if (pf_ready) state_q <= DECODE;
        DECODE: begin
          // illegal opcode parks the core here
          if (illegal) begin
            halted_o <= 1'b1;
          end else begin
            state_q <= EXECUTE;
          end
        end
        EXECUTE: state_q <= (load || store) ? MEMORY : WRITEBACK;
        MEMORY:  if (mem_done) state_q <= WRITEBACK;
        WRITEBACK: begin
          pc_q    <= next_pc_q;
          state_q <= FETCH;
        end
        default: state_q <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == EXECUTE) begin
      if (jal || (branch && cond_true)) begin
        next_pc_q <= pc_q + immediate;
      end else if (jalr) begin
        next_pc_q <= {alu_result[rv32_pkg::XLEN-1:1], 1'b0};
      end else begin
        next_pc_q <= pc_plus4;
      end
      wb_data_q <= (jal || jalr) ? pc_plus4 : alu_result;
    end else if ((state_q == MEMORY) && mem_done) begin
      wb_data_q <= mem_rdata;
    end
  end

  assign debug_o = pc_q[15:2];

  // only the granted unit may strobe
  assert property (@(posedge clk_i) disable iff (reset_i) mem_stb |-> grant_q[1] && !pf_stb);

endmodule

/* design/rv32_memory.sv */
`timescale 1ns/1ps

module rv32_memory (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      start_i,
  input  logic                      write_i,
  input  logic [rv32_pkg::XLEN-1:0] addr_i,
  input  logic [rv32_pkg::XLEN-1:0] data_i,
  output logic [rv32_pkg::XLEN-1:0] data_o,
  output logic                      done_o,
  output logic                      ctrl_req_o,
  input  logic                      ctrl_grant_i,
  input  logic [rv32_pkg::XLEN-1:0] dat_i,
  input  logic                      ack_i,
  output logic [rv32_pkg::XLEN-1:0] dat_o,
  output logic [rv32_pkg::XLEN-3:0] adr_o,
  output logic [3:0]                sel_o,
  output logic                      cyc_o,
  output logic                      stb_o,
  output logic                      we_o
);

  logic req_q;

  assign ctrl_req_o = req_q;
  // word accesses only
  assign sel_o = 4'b1111;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      cyc_o  <= 1'b0;
      stb_o  <= 1'b0;
      we_o   <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        req_q <= 1'b1;
        we_o  <= write_i;
      end else if (stb_o && ack_i) begin
        req_q  <= 1'b0;
        cyc_o  <= 1'b0;
        stb_o  <= 1'b0;
        we_o   <= 1'b0;
        done_o <= 1'b1;
      end else if (req_q && ctrl_grant_i && !cyc_o) begin
        cyc_o <= 1'b1;
        stb_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      adr_o <= addr_i[rv32_pkg::XLEN-1:2];
      dat_o <= data_i;
    end
    if (stb_o && ack_i) begin
      data_o <= dat_i;
    end
  end

  // address held through wait states
  assert property (@(posedge clk_i) disable iff (reset_i)
    stb_o && !ack_i |=> $stable(adr_o));

endmodule

/* design/rv32_alu.sv */
`timescale 1ns/1ps

module rv32_alu (
  input  rv32_pkg::alu_op_e         operation_i,
  input  logic [rv32_pkg::XLEN-1:0] operand1_i,
  input  logic [rv32_pkg::XLEN-1:0] operand2_i,
  output logic [rv32_pkg::XLEN-1:0] result_o,
  output logic                      equal_o,
  output logic                      less_o,
  output logic                      less_unsigned_o
);

  logic [4:0] shamt;

  assign shamt           = operand2_i[4:0];
  assign equal_o         = (operand1_i == operand2_i);
  assign less_o          = ($signed(operand1_i) < $signed(operand2_i));
  assign less_unsigned_o = (operand1_i < operand2_i);

  always_comb begin
    case (operation_i)
      rv32_pkg::ADD:    result_o = operand1_i + operand2_i;
      rv32_pkg::SUB:    result_o = operand1_i - operand2_i;
      rv32_pkg::SLL:    result_o = operand1_i << shamt;
      rv32_pkg::SLT:    result_o = {{(rv32_pkg::XLEN-1){1'b0}}, less_o};
      rv32_pkg::SLTU:   result_o = {{(rv32_pkg::XLEN-1){1'b0}}, less_unsigned_o};
      rv32_pkg::XOR:    result_o = operand1_i ^ operand2_i;
      rv32_pkg::SRL:    result_o = operand1_i >> shamt;
      rv32_pkg::SRA:    result_o = $unsigned($signed(operand1_i) >>> shamt);
      rv32_pkg::OR:     result_o = operand1_i | operand2_i;
      rv32_pkg::AND:    result_o = operand1_i & operand2_i;
      rv32_pkg::PASS_B: result_o = operand2_i;
      default:          result_o = '0;
    endcase
  end

endmodule

/* design/rv32_registers.sv */
`timescale 1ns/1ps

module rv32_registers (
  input  logic                          clk_i,
  input  logic                          write_i,
  input  logic [rv32_pkg::REG_BITS-1:0] rd_addr_i,
  input  logic [rv32_pkg::XLEN-1:0]     data_i,
  input  logic [rv32_pkg::REG_BITS-1:0] rs1_addr_i,
  input  logic [rv32_pkg::REG_BITS-1:0] rs2_addr_i,
  output logic [rv32_pkg::XLEN-1:0]     rs1_o,
  output logic [rv32_pkg::XLEN-1:0]     rs2_o
);

  // x0 has no storage
  logic [rv32_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (write_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= data_i;
    end
  end

  assign rs1_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* design/rv32_decode.sv */
`timescale 1ns/1ps

module rv32_decode (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          data_ready_i,
  input  logic [rv32_pkg::XLEN-1:0]     instruction_i,
  output logic [rv32_pkg::REG_BITS-1:0] rs1_addr_o,
  output logic [rv32_pkg::REG_BITS-1:0] rs2_addr_o,
  output logic [rv32_pkg::REG_BITS-1:0] rd_addr_o,
  output logic [rv32_pkg::XLEN-1:0]     immediate_o,
  output rv32_pkg::alu_op_e             alu_op_o,
  output logic                          use_imm_o,
  output logic                          use_pc_o,
  output logic                          jal_o,
  output logic                          jalr_o,
  output logic                          branch_o,
  output logic                          load_o,
  output logic                          store_o,
  output logic                          reg_write_o,
  output rv32_pkg::branch_cond_e        branch_cond_o,
  output logic                          illegal_o
);

  rv32_pkg::opcode_e            opcode;
  logic [2:0]                   funct3;
  logic [rv32_pkg::XLEN-1:0]    imm_i, imm_s, imm_b, imm_u, imm_j, imm_d;
  rv32_pkg::alu_op_e            alu_op_d;
  logic use_imm_d, use_pc_d, jal_d, jalr_d, branch_d;
  logic load_d, store_d, reg_write_d, illegal_d;

  // alt from instruction bit 30 selects SUB/SRA
  function automatic rv32_pkg::alu_op_e funct_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    funct_to_op = alt ? rv32_pkg::SUB : rv32_pkg::ADD;
      3'd1:    funct_to_op = rv32_pkg::SLL;
      3'd2:    funct_to_op = rv32_pkg::SLT;
      3'd3:    funct_to_op = rv32_pkg::SLTU;
      3'd4:    funct_to_op = rv32_pkg::XOR;
      3'd5:    funct_to_op = alt ? rv32_pkg::SRA : rv32_pkg::SRL;
      3'd6:    funct_to_op = rv32_pkg::OR;
      default: funct_to_op = rv32_pkg::AND;
    endcase
  endfunction

  assign opcode = rv32_pkg::opcode_e'(instruction_i[6:0]);
  assign funct3 = instruction_i[14:12];

  assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
  assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
  assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                  instruction_i[30:25], instruction_i[11:8], 1'b0};
  assign imm_u = {instruction_i[31:12], 12'b0};
  assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                  instruction_i[20], instruction_i[30:21], 1'b0};

  always_comb begin
    imm_d       = imm_i;
    alu_op_d    = rv32_pkg::ADD;
    use_imm_d   = 1'b1;
    use_pc_d    = 1'b0;
    jal_d       = 1'b0;
    jalr_d      = 1'b0;
    branch_d    = 1'b0;
    load_d      = 1'b0;
    store_d     = 1'b0;
    reg_write_d = 1'b0;
    illegal_d   = 1'b0;
    case (opcode)
      rv32_pkg::OP_LUI: begin
        imm_d       = imm_u;
        alu_op_d    = rv32_pkg::PASS_B;
        reg_write_d = 1'b1;
      end
      rv32_pkg::OP_AUIPC: begin
        imm_d       = imm_u;
        use_pc_d    = 1'b1;
        reg_write_d = 1'b1;
      end
      rv32_pkg::OP_JAL: begin
        imm_d       = imm_j;
        jal_d       = 1'b1;
        reg_write_d = 1'b1;
      end
      rv32_pkg::OP_JALR: begin
        jalr_d      = 1'b1;
        reg_write_d = 1'b1;
      end
      rv32_pkg::OP_BRANCH: begin
        // rs1 compared against rs2 and target taken as pc + imm
        imm_d     = imm_b;
        alu_op_d  = rv32_pkg::SUB;
        use_imm_d = 1'b0;
        branch_d  = 1'b1;
        illegal_d = (funct3[2:1] == 2'b01);
      end
      rv32_pkg::OP_LOAD: begin
        load_d      = 1'b1;
        reg_write_d = 1'b1;
        illegal_d   = (funct3 != 3'b010);
      end
      rv32_pkg::OP_STORE: begin
        imm_d     = imm_s;
        store_d   = 1'b1;
        illegal_d = (funct3 != 3'b010);
      end
      rv32_pkg::OP_IMM: begin
        alu_op_d    = funct_to_op(funct3, instruction_i[30] && (funct3 == 3'd5));
        reg_write_d = 1'b1;
      end
      rv32_pkg::OP_REG: begin
        alu_op_d    = funct_to_op(funct3, instruction_i[30]);
        use_imm_d   = 1'b0;
        reg_write_d = 1'b1;
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      jal_o       <= 1'b0;
      jalr_o      <= 1'b0;
      branch_o    <= 1'b0;
      load_o      <= 1'b0;
      store_o     <= 1'b0;
      reg_write_o <= 1'b0;
      illegal_o   <= 1'b0;
    end else if (data_ready_i) begin
      jal_o       <= jal_d;
      jalr_o      <= jalr_d;
      branch_o    <= branch_d;
      load_o      <= load_d;
      store_o     <= store_d;
      reg_write_o <= reg_write_d;
      illegal_o   <= illegal_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_ready_i) begin
      rs1_addr_o    <= instruction_i[19:15];
      rs2_addr_o    <= instruction_i[24:20];
      rd_addr_o     <= instruction_i[11:7];
      immediate_o   <= imm_d;
      alu_op_o      <= alu_op_d;
      use_imm_o     <= use_imm_d;
      use_pc_o      <= use_pc_d;
      branch_cond_o <= rv32_pkg::branch_cond_e'(funct3);
    end
  end

endmodule

/* design/rv32_prefetch.sv */
`timescale 1ns/1ps

module rv32_prefetch #(
  parameter logic [rv32_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      advance_i,
  input  logic [rv32_pkg::XLEN-1:0] pc_i,
  output logic                      data_ready_o,
  output logic [rv32_pkg::XLEN-1:0] instruction_o,
  output logic                      ctrl_req_o,
  input  logic                      ctrl_grant_i,
  input  logic [rv32_pkg::XLEN-1:0] dat_i,
  input  logic                      ack_i,
  output logic [rv32_pkg::XLEN-3:0] adr_o,
  output logic                      cyc_o,
  output logic                      stb_o
);

  typedef enum logic [1:0] {PF_IDLE, PF_REQUEST, PF_WAIT} pf_state_e;

  pf_state_e state_q;

  assign ctrl_req_o = (state_q != PF_IDLE);

  // first fetch after reset needs no advance
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= PF_REQUEST;
      adr_o        <= RESET_PC[rv32_pkg::XLEN-1:2];
      cyc_o        <= 1'b0;
      stb_o        <= 1'b0;
      data_ready_o <= 1'b0;
    end else begin
      data_ready_o <= 1'b0;
      case (state_q)
        PF_IDLE: begin
          if (advance_i) begin
            adr_o   <= pc_i[rv32_pkg::XLEN-1:2];
            state_q <= PF_REQUEST;
          end
        end
        PF_REQUEST: begin
          if (ctrl_grant_i) begin
            cyc_o   <= 1'b1;
            stb_o   <= 1'b1;
            state_q <= PF_WAIT;
          end
        end
        PF_WAIT: begin
          if (ack_i) begin
            cyc_o        <= 1'b0;
            stb_o        <= 1'b0;
            data_ready_o <= 1'b1;
            state_q      <= PF_IDLE;
          end
        end
        default: state_q <= PF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_o && ack_i) begin
      instruction_o <= dat_i;
    end
  end

  // strobe only on a bus the core has handed over
  assert property (@(posedge clk_i) disable iff (reset_i) stb_o |-> cyc_o && ctrl_grant_i);

endmodule

/* design/rv32_pkg.sv */
package rv32_pkg;

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  // major opcodes in bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_e;

  // same encoding as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_cond_e;

endpackage
